/* all.f */
+incdir+common
common/cpuPkg.sv
common/busCtrlIf.sv
common/memIf.sv
datapath/alu.sv
datapath/regFile.sv
datapath/dataPath.sv
src/memory.sv
src/controlSeq.sv
src/hostRegs.sv
src/cpuTop.sv
verif/cpuTb.sv

/* common/busCtrlIf.sv */
// Sequencer to datapath controls; all signals are combinational within one T-state
`timescale 1ns/1ns

interface busCtrlIf;
   cpuPkg::busSrcT busSrc;
   // Register load enables
   logic pcIn, irIn, marIn, mdrIn, yIn, zIn, rIn;
   // Register field select and base-zero rule
   logic gra, grb, grc;
   logic baOut;
   logic incPc;
   cpuPkg::aluOpT aluOp;
   logic memRead;
   logic memWrite;
   logic conIn;
   // Status back from the datapath
   cpuPkg::opcodeT irOpcode;
   logic conFlag;

   modport seq (
      output busSrc, pcIn, irIn, marIn, mdrIn, yIn, zIn, rIn,
      output gra, grb, grc, baOut, incPc, aluOp, memRead, memWrite, conIn,
      input  irOpcode, conFlag
   );

   modport dp (
      input  busSrc, pcIn, irIn, marIn, mdrIn, yIn, zIn, rIn,
      input  gra, grb, grc, baOut, incPc, aluOp, memRead, memWrite, conIn,
      output irOpcode, conFlag
   );
endinterface

/* common/cpuPkg.sv */
// Shared CPU types; opcode values are the binary encoding of IR bits 31..27
package cpuPkg;

   typedef enum logic [4:0] {
      opLd   = 5'd0,
      opSt   = 5'd1,
      opAddi = 5'd2,
      opAdd  = 5'd3,
      opSub  = 5'd4,
      opAnd  = 5'd5,
      opOr   = 5'd6,
      opShl  = 5'd7,
      opBrzr = 5'd8,
      opHalt = 5'd9
   } opcodeT;

   typedef enum logic [2:0] {
      aluAdd,
      aluSub,
      aluAnd,
      aluOr,
      aluShl,
      aluPassB
   } aluOpT;

   // Single driver of the shared bus
   typedef enum logic [2:0] {
      srcNone,
      srcPc,
      srcMdr,
      srcZLo,
      srcRegFile,
      srcImm,
      srcPcInit
   } busSrcT;

   typedef enum logic [3:0] {
      sIdle,
      sLoad,
      sT0,
      sT1,
      sT2,
      sT3,
      sT4,
      sT5,
      sT6,
      sT7,
      sHalted
   } seqStateT;

endpackage

/* common/cpu_cfg.svh */
// Widths, depths and host register offsets; MEM_ADDR_W must equal clog2 of MEM_DEPTH
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

`define DATA_WIDTH 32
`define MEM_DEPTH 512
`define MEM_ADDR_W 9
`define REG_COUNT 16
`define REG_SEL_W 4
`define AXI_ADDR_W 8

`define REG_CTRL 8'h00
`define REG_STATUS 8'h04
`define REG_PCINIT 8'h08
`define REG_MEMADDR 8'h0C
`define REG_MEMDATA 8'h10

`endif

/* common/memIf.sv */
// CPU memory port; rdData is registered and valid the cycle after re
`timescale 1ns/1ns
`include "cpu_cfg.svh"

interface memIf;
   logic [`MEM_ADDR_W-1:0] addr;
   logic [`DATA_WIDTH-1:0] wrData;
   logic we;
   logic re;
   logic [`DATA_WIDTH-1:0] rdData;

   modport cpu (
      output addr, wrData, we, re,
      input  rdData
   );

   modport mem (
      input  addr, wrData, we, re,
      output rdData
   );
endinterface

/* datapath/alu.sv */
// Combinational ALU on Y and the bus; shift amount uses the low 5 bits of b only
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module alu (
   input  cpuPkg::aluOpT          op,
   input  logic [`DATA_WIDTH-1:0] a,
   input  logic [`DATA_WIDTH-1:0] b,
   output logic [`DATA_WIDTH-1:0] result
);

   always_comb begin
      case (op)
         cpuPkg::aluAdd: result = a + b;
         cpuPkg::aluSub: result = a - b;
         cpuPkg::aluAnd: result = a & b;
         cpuPkg::aluOr:  result = a | b;
         cpuPkg::aluShl: result = a << b[4:0];
         // passB and unused codes
         default:        result = b;
      endcase
   end

endmodule

/* datapath/dataPath.sv */
// Single-bus datapath; memory address and write data pass through when MAR or MDR loads
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module dataPath (
   input  logic                   Clock,
   input  logic                   rstN,
   input  logic [`DATA_WIDTH-1:0] pcInit,
   busCtrlIf.dp                   ctrl,
   memIf.cpu                      mem
);

   logic [`DATA_WIDTH-1:0] bus;
   logic [`DATA_WIDTH-1:0] pc;
   logic [`DATA_WIDTH-1:0] ir;
   logic [`MEM_ADDR_W-1:0] mar;
   logic [`DATA_WIDTH-1:0] mdr;
   logic [`DATA_WIDTH-1:0] y;
   logic [`DATA_WIDTH-1:0] z;
   logic [`DATA_WIDTH-1:0] immExt;
   logic [`DATA_WIDTH-1:0] regRd;
   logic [`DATA_WIDTH-1:0] aluResult;
   logic [`REG_SEL_W-1:0]  regSel;
   logic                   memReadQ;
   logic                   conFlagQ;

   // Signed 19-bit immediate
   assign immExt = {{(`DATA_WIDTH - 19){ir[18]}}, ir[18:0]};

   // Field select, register 0 when nothing is chosen
   always_comb begin
      if (ctrl.gra) begin
         regSel = ir[26:23];
      end else if (ctrl.grb) begin
         regSel = ir[22:19];
      end else if (ctrl.grc) begin
         regSel = ir[18:15];
      end else begin
         regSel = '0;
      end
   end

   always_comb begin
      case (ctrl.busSrc)
         cpuPkg::srcPc:      bus = pc;
         cpuPkg::srcMdr:     bus = mdr;
         cpuPkg::srcZLo:     bus = z;
         cpuPkg::srcRegFile: bus = (ctrl.baOut && regSel == '0) ? '0 : regRd;
         cpuPkg::srcImm:     bus = immExt;
         cpuPkg::srcPcInit:  bus = pcInit;
         default:            bus = '0;
      endcase
   end

   regFile regFile_i (
      .Clock  (Clock),
      .rstN   (rstN),
      .sel    (regSel),
      .we     (ctrl.rIn),
      .wrData (bus),
      .rdData (regRd)
   );

   alu alu_i (
      .op     (ctrl.aluOp),
      .a      (y),
      .b      (bus),
      .result (aluResult)
   );

   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) begin
         pc       <= '0;
         ir       <= '0;
         memReadQ <= 1'b0;
         conFlagQ <= 1'b0;
      end else begin
         memReadQ <= ctrl.memRead;
         if (ctrl.pcIn) begin
            pc <= bus;
         end else if (ctrl.incPc) begin
            pc <= pc + `DATA_WIDTH'(1);
         end
         if (ctrl.irIn) begin
            ir <= bus;
         end
         // Branch test on the selected register, independent of the bus
         if (ctrl.conIn) begin
            conFlagQ <= (regRd == '0);
         end
      end
   end

   always_ff @(posedge Clock) begin
      if (ctrl.marIn) begin
         mar <= bus[`MEM_ADDR_W-1:0];
      end
      if (ctrl.mdrIn) begin
         mdr <= memReadQ ? mem.rdData : bus;
      end
      if (ctrl.yIn) begin
         y <= bus;
      end
      if (ctrl.zIn) begin
         z <= aluResult;
      end
   end

   assign mem.addr      = ctrl.marIn ? bus[`MEM_ADDR_W-1:0] : mar;
   assign mem.wrData    = ctrl.mdrIn ? bus : mdr;
   assign mem.we        = ctrl.memWrite;
   assign mem.re        = ctrl.memRead;
   assign ctrl.irOpcode = cpuPkg::opcodeT'(ir[31:27]);
   assign ctrl.conFlag  = conFlagQ;

endmodule

/* datapath/regFile.sv */
// General registers with combinational read; register 0 is an ordinary register here
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module regFile (
   input  logic                   Clock,
   input  logic                   rstN,
   input  logic [`REG_SEL_W-1:0]  sel,
   input  logic                   we,
   input  logic [`DATA_WIDTH-1:0] wrData,
   output logic [`DATA_WIDTH-1:0] rdData
);

   logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) begin
         for (int i = 0; i < `REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (we) begin
         regs[sel] <= wrData;
      end
   end

   assign rdData = regs[sel];

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module cpuTb -f all.f -o cpuTbSim
./obj_dir/cpuTbSim | tee sim.log
if grep -q "All checks passed" sim.log; then
   echo "Simulation passed"
   exit 0
else
   echo "Simulation failed, see sim.log"
   exit 1
fi

/* src/controlSeq.sv */
// T-state sequencer; unknown opcodes stop the CPU as halt does, st finishes in t6
`timescale 1ns/1ns

module controlSeq (
   input  logic   Clock,
   input  logic   rstN,
   input  logic   startPulse,
   busCtrlIf.seq  ctrl,
   output logic   running,
   output logic   halted
);

   cpuPkg::seqStateT state;
   cpuPkg::seqStateT nextState;
   cpuPkg::opcodeT   op;
   logic             isAluOp;
   logic             isMemOp;
   logic             isKnown;

   assign op      = ctrl.irOpcode;
   assign isAluOp = op inside {cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opAnd,
                               cpuPkg::opOr, cpuPkg::opShl};
   assign isMemOp = op inside {cpuPkg::opLd, cpuPkg::opSt};
   assign isKnown = isAluOp || isMemOp || op inside {cpuPkg::opAddi, cpuPkg::opBrzr};

   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) begin
         state <= cpuPkg::sIdle;
      end else begin
         state <= nextState;
      end
   end

   always_comb begin
      nextState = state;
      case (state)
         cpuPkg::sIdle,
         cpuPkg::sHalted: if (startPulse) nextState = cpuPkg::sLoad;
         cpuPkg::sLoad:   nextState = cpuPkg::sT0;
         cpuPkg::sT0:     nextState = cpuPkg::sT1;
         cpuPkg::sT1:     nextState = cpuPkg::sT2;
         cpuPkg::sT2:     nextState = cpuPkg::sT3;
         cpuPkg::sT3:     nextState = isKnown ? cpuPkg::sT4 : cpuPkg::sHalted;
         cpuPkg::sT4:     nextState = cpuPkg::sT5;
         cpuPkg::sT5:     nextState = isMemOp ? cpuPkg::sT6 : cpuPkg::sT0;
         cpuPkg::sT6:     nextState = (op == cpuPkg::opLd) ? cpuPkg::sT7 : cpuPkg::sT0;
         default:         nextState = cpuPkg::sT0;
      endcase
   end

   always_comb begin
      ctrl.busSrc   = cpuPkg::srcNone;
      ctrl.pcIn     = 1'b0;
      ctrl.irIn     = 1'b0;
      ctrl.marIn    = 1'b0;
      ctrl.mdrIn    = 1'b0;
      ctrl.yIn      = 1'b0;
      ctrl.zIn      = 1'b0;
      ctrl.rIn      = 1'b0;
      ctrl.gra      = 1'b0;
      ctrl.grb      = 1'b0;
      ctrl.grc      = 1'b0;
      ctrl.baOut    = 1'b0;
      ctrl.incPc    = 1'b0;
      ctrl.aluOp    = cpuPkg::aluAdd;
      ctrl.memRead  = 1'b0;
      ctrl.memWrite = 1'b0;
      ctrl.conIn    = 1'b0;
      case (state)
         cpuPkg::sLoad: begin
            ctrl.busSrc = cpuPkg::srcPcInit;
            ctrl.pcIn   = 1'b1;
         end
         cpuPkg::sT0: begin
            ctrl.busSrc  = cpuPkg::srcPc;
            ctrl.marIn   = 1'b1;
            ctrl.memRead = 1'b1;
         end
         cpuPkg::sT1: begin
            ctrl.mdrIn = 1'b1;
            ctrl.incPc = 1'b1;
         end
         cpuPkg::sT2: begin
            ctrl.busSrc = cpuPkg::srcMdr;
            ctrl.irIn   = 1'b1;
         end
         cpuPkg::sT3: begin
            ctrl.yIn = 1'b1;
            if (op == cpuPkg::opBrzr) begin
               // PC into Y while ra is tested
               ctrl.busSrc = cpuPkg::srcPc;
               ctrl.gra    = 1'b1;
               ctrl.conIn  = 1'b1;
            end else begin
               ctrl.busSrc = cpuPkg::srcRegFile;
               ctrl.grb    = 1'b1;
               ctrl.baOut  = isMemOp;
            end
         end
         cpuPkg::sT4: begin
            ctrl.zIn = 1'b1;
            if (isAluOp) begin
               ctrl.busSrc = cpuPkg::srcRegFile;
               ctrl.grc    = 1'b1;
               case (op)
                  cpuPkg::opSub: ctrl.aluOp = cpuPkg::aluSub;
                  cpuPkg::opAnd: ctrl.aluOp = cpuPkg::aluAnd;
                  cpuPkg::opOr:  ctrl.aluOp = cpuPkg::aluOr;
                  cpuPkg::opShl: ctrl.aluOp = cpuPkg::aluShl;
                  default:       ctrl.aluOp = cpuPkg::aluAdd;
               endcase
            end else begin
               ctrl.busSrc = cpuPkg::srcImm;
            end
         end
         cpuPkg::sT5: begin
            ctrl.busSrc = cpuPkg::srcZLo;
            if (isMemOp) begin
               ctrl.marIn   = 1'b1;
               ctrl.memRead = (op == cpuPkg::opLd);
            end else if (op == cpuPkg::opBrzr) begin
               ctrl.pcIn = ctrl.conFlag;
            end else begin
               ctrl.gra = 1'b1;
               ctrl.rIn = 1'b1;
            end
         end
         cpuPkg::sT6: begin
            ctrl.mdrIn = 1'b1;
            // st writes ra through MDR in the same cycle
            if (op == cpuPkg::opSt) begin
               ctrl.busSrc   = cpuPkg::srcRegFile;
               ctrl.gra      = 1'b1;
               ctrl.memWrite = 1'b1;
            end
         end
         cpuPkg::sT7: begin
            ctrl.busSrc = cpuPkg::srcMdr;
            ctrl.gra    = 1'b1;
            ctrl.rIn    = 1'b1;
         end
         default: begin
         end
      endcase
   end

   assign running = !(state inside {cpuPkg::sIdle, cpuPkg::sHalted});
   assign halted  = (state == cpuPkg::sHalted);

endmodule

/* src/cpuTop.sv */
// CPU top with AXI4-Lite host port; the host owns memory only while the CPU is stopped
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module cpuTop (
   input  logic                   Clock,
   input  logic                   rstN,
   input  logic [`AXI_ADDR_W-1:0] awAddr,
   input  logic                   awValid,
   output logic                   awReady,
   input  logic [`DATA_WIDTH-1:0] wData,
   input  logic                   wValid,
   output logic                   wReady,
   output logic [1:0]             bResp,
   output logic                   bValid,
   input  logic                   bReady,
   input  logic [`AXI_ADDR_W-1:0] arAddr,
   input  logic                   arValid,
   output logic                   arReady,
   output logic [`DATA_WIDTH-1:0] rData,
   output logic [1:0]             rResp,
   output logic                   rValid,
   input  logic                   rReady
);

   logic                   startPulse;
   logic                   running;
   logic                   halted;
   logic [`DATA_WIDTH-1:0] pcInit;
   logic [`MEM_ADDR_W-1:0] hostAddr;
   logic                   hostWe;
   logic [`DATA_WIDTH-1:0] hostWrData;
   logic [`DATA_WIDTH-1:0] hostRdData;

   busCtrlIf busCtrl ();
   memIf     memBus ();

   hostRegs hostRegs_i (
      .Clock      (Clock),
      .rstN       (rstN),
      .awAddr     (awAddr),
      .awValid    (awValid),
      .awReady    (awReady),
      .wData      (wData),
      .wValid     (wValid),
      .wReady     (wReady),
      .bResp      (bResp),
      .bValid     (bValid),
      .bReady     (bReady),
      .arAddr     (arAddr),
      .arValid    (arValid),
      .arReady    (arReady),
      .rData      (rData),
      .rResp      (rResp),
      .rValid     (rValid),
      .rReady     (rReady),
      .running    (running),
      .halted     (halted),
      .hostRdData (hostRdData),
      .startPulse (startPulse),
      .pcInit     (pcInit),
      .hostAddr   (hostAddr),
      .hostWe     (hostWe),
      .hostWrData (hostWrData)
   );

   controlSeq controlSeq_i (
      .Clock      (Clock),
      .rstN       (rstN),
      .startPulse (startPulse),
      .ctrl       (busCtrl.seq),
      .running    (running),
      .halted     (halted)
   );

   dataPath dataPath_i (
      .Clock  (Clock),
      .rstN   (rstN),
      .pcInit (pcInit),
      .ctrl   (busCtrl.dp),
      .mem    (memBus.cpu)
   );

   memory memory_i (
      .Clock      (Clock),
      .port       (memBus.mem),
      .hostAddr   (hostAddr),
      .hostWe     (hostWe),
      .hostWrData (hostWrData),
      .hostRdData (hostRdData)
   );

endmodule

/* src/hostRegs.sv */
// AXI4-Lite slave, one outstanding transfer per channel; MEMDATA while running gives SLVERR
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module hostRegs (
   input  logic                   Clock,
   input  logic                   rstN,
   input  logic [`AXI_ADDR_W-1:0] awAddr,
   input  logic                   awValid,
   output logic                   awReady,
   input  logic [`DATA_WIDTH-1:0] wData,
   input  logic                   wValid,
   output logic                   wReady,
   output logic [1:0]             bResp,
   output logic                   bValid,
   input  logic                   bReady,
   input  logic [`AXI_ADDR_W-1:0] arAddr,
   input  logic                   arValid,
   output logic                   arReady,
   output logic [`DATA_WIDTH-1:0] rData,
   output logic [1:0]             rResp,
   output logic                   rValid,
   input  logic                   rReady,
   input  logic                   running,
   input  logic                   halted,
   input  logic [`DATA_WIDTH-1:0] hostRdData,
   output logic                   startPulse,
   output logic [`DATA_WIDTH-1:0] pcInit,
   output logic [`MEM_ADDR_W-1:0] hostAddr,
   output logic                   hostWe,
   output logic [`DATA_WIDTH-1:0] hostWrData
);

   localparam logic [1:0] RespOkay   = 2'b00;
   localparam logic [1:0] RespSlvErr = 2'b10;

   logic [`MEM_ADDR_W-1:0] memAddr;
   logic [`AXI_ADDR_W-1:0] rdAddr;
   logic [`DATA_WIDTH-1:0] readMux;
   logic                   wrFire;
   logic                   wrMemData;
   logic                   rdFire;
   logic                   rdMemData;
   logic                   rdStage;
   logic                   rdErr;

   assign wrFire     = awReady && awValid && wValid;
   assign wrMemData  = (awAddr == `REG_MEMDATA);
   assign rdFire     = arReady && arValid;
   assign rdMemData  = (arAddr == `REG_MEMDATA);
   assign hostAddr   = memAddr;
   assign hostWe     = wrFire && wrMemData && !running;
   assign hostWrData = wData;

   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) begin
         awReady    <= 1'b0;
         wReady     <= 1'b0;
         bValid     <= 1'b0;
         bResp      <= RespOkay;
         arReady    <= 1'b0;
         rdStage    <= 1'b0;
         rValid     <= 1'b0;
         rResp      <= RespOkay;
         rdErr      <= 1'b0;
         rdAddr     <= '0;
         memAddr    <= '0;
         pcInit     <= '0;
         startPulse <= 1'b0;
      end else begin
         // Ready pulses for one cycle, blocked while a response is pending
         awReady    <= awValid && wValid && !awReady && !bValid;
         wReady     <= awValid && wValid && !awReady && !bValid;
         arReady    <= arValid && !arReady && !rdStage && !rValid;
         rdStage    <= rdFire;
         startPulse <= 1'b0;
         if (bValid && bReady) begin
            bValid <= 1'b0;
         end
         if (wrFire) begin
            bValid <= 1'b1;
            bResp  <= (wrMemData && running) ? RespSlvErr : RespOkay;
            case (awAddr)
               `REG_CTRL:    startPulse <= wData[0] && !running;
               `REG_PCINIT:  pcInit <= wData;
               `REG_MEMADDR: memAddr <= wData[`MEM_ADDR_W-1:0];
               `REG_MEMDATA: if (!running) memAddr <= memAddr + 1'b1;
               default: begin
               end
            endcase
         end
         if (rdFire) begin
            rdAddr <= arAddr;
            rdErr  <= rdMemData && running;
            if (rdMemData && !running) begin
               memAddr <= memAddr + 1'b1;
            end
         end
         // Memory data is ready one cycle after the address
         if (rdStage) begin
            rValid <= 1'b1;
            rResp  <= rdErr ? RespSlvErr : RespOkay;
         end else if (rValid && rReady) begin
            rValid <= 1'b0;
         end
      end
   end

   always_comb begin
      case (rdAddr)
         `REG_STATUS:  readMux = `DATA_WIDTH'({halted, running});
         `REG_PCINIT:  readMux = pcInit;
         `REG_MEMADDR: readMux = `DATA_WIDTH'(memAddr);
         `REG_MEMDATA: readMux = rdErr ? '0 : hostRdData;
         default:      readMux = '0;
      endcase
   end

   always_ff @(posedge Clock) begin
      if (rdStage) begin
         rData <= readMux;
      end
   end

endmodule

/* src/memory.sv */
// Word memory with CPU and host ports; the host port is only used while the CPU is stopped
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module memory (
   input  logic                   Clock,
   memIf.mem                      port,
   input  logic [`MEM_ADDR_W-1:0] hostAddr,
   input  logic                   hostWe,
   input  logic [`DATA_WIDTH-1:0] hostWrData,
   output logic [`DATA_WIDTH-1:0] hostRdData
);

   logic [`DATA_WIDTH-1:0] mem [`MEM_DEPTH];

   always_ff @(posedge Clock) begin
      if (hostWe) begin
         mem[hostAddr] <= hostWrData;
      end else if (port.we) begin
         mem[port.addr] <= port.wrData;
      end
      if (port.re) begin
         port.rdData <= mem[port.addr];
      end
      // Host read runs every cycle
      hostRdData <= mem[hostAddr];
   end

endmodule

/* verif/cpuTb.sv */
// CPU testbench over AXI4-Lite; programs and data stay inside fixed 64-word windows
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module cpuTb;

   localparam logic [1:0] Okay   = 2'b00;
   localparam logic [1:0] SlvErr = 2'b10;
   localparam int Base1 = 'h180;
   localparam int Base2 = 'h040;
   localparam int Base3 = 'h080;
   localparam int Base4 = 'h0C0;
   localparam int Window = 64;
   // Worst-case instructions over all programs, 8 cycles each
   localparam int InstrWorst = 16 + 16 + (2 + 19 * 4 + 4);
   // Window loads and readbacks, register accesses, STATUS polls
   localparam int AxiOps = 4 * (Window * 2 + 8) + 8 + InstrWorst * 2;
   localparam int TimeoutCycles = 10 + InstrWorst * 8 + AxiOps * 40;

   logic                   Clock;
   logic                   rstN;
   logic [`AXI_ADDR_W-1:0] awAddr;
   logic                   awValid;
   logic                   awReady;
   logic [`DATA_WIDTH-1:0] wData;
   logic                   wValid;
   logic                   wReady;
   logic [1:0]             bResp;
   logic                   bValid;
   logic                   bReady;
   logic [`AXI_ADDR_W-1:0] arAddr;
   logic                   arValid;
   logic                   arReady;
   logic [`DATA_WIDTH-1:0] rData;
   logic [1:0]             rResp;
   logic                   rValid;
   logic                   rReady;

   logic [31:0] lfsr;
   logic [31:0] refMem [`MEM_DEPTH];
   logic [31:0] refRegs [`REG_COUNT];
   logic [8:0]  emitPtr;
   int          dataErrs;
   int          respErrs;
   int          cycleCount;

   cpuTop cpuTop_i (
      .Clock   (Clock),
      .rstN    (rstN),
      .awAddr  (awAddr),
      .awValid (awValid),
      .awReady (awReady),
      .wData   (wData),
      .wValid  (wValid),
      .wReady  (wReady),
      .bResp   (bResp),
      .bValid  (bValid),
      .bReady  (bReady),
      .arAddr  (arAddr),
      .arValid (arValid),
      .arReady (arReady),
      .rData   (rData),
      .rResp   (rResp),
      .rValid  (rValid),
      .rReady  (rReady)
   );

   initial begin
      Clock = 1'b0;
      forever #2 Clock = ~Clock;
   end

   initial begin
      cycleCount = 0;
      while (cycleCount < TimeoutCycles) begin
         @(posedge Clock);
         cycleCount++;
      end
      $display("Timeout after %0d cycles, the DUT stopped answering", cycleCount);
      $display("Checks failed");
      $finish;
   end

   // Galois LFSR, one step per bit taken
   function automatic logic [31:0] randBits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
         v = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   function automatic logic [31:0] fillWord(input logic [8:0] a);
      return {7'h5A, a, 7'h13, ~a};
   endfunction

   function automatic logic [31:0] encR(input cpuPkg::opcodeT op, input int ra, input int rb,
                                        input int rc);
      return {op, ra[3:0], rb[3:0], rc[3:0], 15'd0};
   endfunction

   function automatic logic [31:0] encI(input cpuPkg::opcodeT op, input int ra, input int rb,
                                        input int imm);
      return {op, ra[3:0], rb[3:0], imm[18:0]};
   endfunction

   // Instruction-level model of the program on refMem and refRegs
   function automatic void refRun(input int startPc);
      logic [31:0] pc;
      logic [31:0] ins;
      logic [31:0] immX;
      logic [31:0] base;
      logic [31:0] addr;
      logic [4:0]  op;
      logic [3:0]  ra;
      logic [3:0]  rb;
      logic [3:0]  rc;
      logic        done;
      int          steps;
      pc = startPc;
      done = 1'b0;
      steps = 0;
      while (!done && steps < 1000) begin
         ins = refMem[pc[8:0]];
         pc = pc + 1;
         steps++;
         op = ins[31:27];
         ra = ins[26:23];
         rb = ins[22:19];
         rc = ins[18:15];
         immX = {{13{ins[18]}}, ins[18:0]};
         // Base register 0 reads as zero for ld and st
         base = (rb == 4'd0) ? 32'd0 : refRegs[rb];
         addr = base + immX;
         case (op)
            cpuPkg::opLd:   refRegs[ra] = refMem[addr[8:0]];
            cpuPkg::opSt:   refMem[addr[8:0]] = refRegs[ra];
            cpuPkg::opAddi: refRegs[ra] = refRegs[rb] + immX;
            cpuPkg::opAdd:  refRegs[ra] = refRegs[rb] + refRegs[rc];
            cpuPkg::opSub:  refRegs[ra] = refRegs[rb] - refRegs[rc];
            cpuPkg::opAnd:  refRegs[ra] = refRegs[rb] & refRegs[rc];
            cpuPkg::opOr:   refRegs[ra] = refRegs[rb] | refRegs[rc];
            cpuPkg::opShl:  refRegs[ra] = refRegs[rb] << refRegs[rc][4:0];
            cpuPkg::opBrzr: begin
               if (refRegs[ra] == 32'd0) begin
                  pc = pc + immX;
               end
            end
            default:        done = 1'b1;
         endcase
      end
   endfunction

   task automatic emit(input logic [31:0] ins);
      refMem[emitPtr] = ins;
      emitPtr = emitPtr + 9'd1;
   endtask

   task automatic flagValue(input string what, input logic [31:0] got, input logic [31:0] exp);
      dataErrs++;
      $display("ERR at %0t ns: %s got %h expected %h", $time, what, got, exp);
   endtask

   task automatic flagResp(input string what, input logic [1:0] got, input logic [1:0] exp);
      respErrs++;
      $display("ERR at %0t ns: %s response got %b expected %b", $time, what, got, exp);
   endtask

   // Called and returns on a falling edge; bReady stalls at random
   task automatic axiWrite(input logic [7:0] addr, input logic [31:0] data,
                           output logic [1:0] resp);
      logic [31:0] stall;
      awAddr = addr;
      wData = data;
      awValid = 1'b1;
      wValid = 1'b1;
      @(negedge Clock);
      while (!awReady) @(negedge Clock);
      // Address and data are accepted in the same cycle
      if (wReady !== 1'b1) begin
         respErrs++;
         $display("ERR at %0t ns: wReady low while awReady is high", $time);
      end
      @(negedge Clock);
      awValid = 1'b0;
      wValid = 1'b0;
      while (!bValid) @(negedge Clock);
      stall = randBits(1);
      bReady = stall[0];
      while (!bReady) begin
         @(negedge Clock);
         stall = randBits(1);
         bReady = stall[0];
      end
      resp = bResp;
      @(negedge Clock);
      bReady = 1'b0;
   endtask

   task automatic axiRead(input logic [7:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
      logic [31:0] stall;
      arAddr = addr;
      arValid = 1'b1;
      @(negedge Clock);
      while (!arReady) @(negedge Clock);
      @(negedge Clock);
      arValid = 1'b0;
      while (!rValid) @(negedge Clock);
      stall = randBits(1);
      rReady = stall[0];
      while (!rReady) begin
         @(negedge Clock);
         stall = randBits(1);
         rReady = stall[0];
      end
      data = rData;
      resp = rResp;
      @(negedge Clock);
      rReady = 1'b0;
   endtask

   task automatic writeReg(input logic [7:0] addr, input logic [31:0] data);
      logic [1:0] resp;
      axiWrite(addr, data, resp);
      if (resp !== Okay) flagResp($sformatf("write to %h", addr), resp, Okay);
   endtask

   task automatic readReg(input logic [7:0] addr, output logic [31:0] data);
      logic [1:0] resp;
      axiRead(addr, data, resp);
      if (resp !== Okay) flagResp($sformatf("read from %h", addr), resp, Okay);
   endtask

   task automatic fillWindow(input int base);
      for (int i = 0; i < Window; i++) begin
         refMem[9'(base + i)] = fillWord(9'(base + i));
      end
   endtask

   task automatic loadWindow(input int base, input int n);
      writeReg(`REG_MEMADDR, base);
      for (int i = 0; i < n; i++) begin
         writeReg(`REG_MEMDATA, refMem[9'(base + i)]);
      end
   endtask

   // Reads the window back through MEMDATA and compares with the model
   task automatic checkWindow(input int base, input int n);
      logic [31:0] got;
      writeReg(`REG_MEMADDR, base);
      for (int i = 0; i < n; i++) begin
         readReg(`REG_MEMDATA, got);
         if (got !== refMem[9'(base + i)]) begin
            flagValue($sformatf("memory word %h", 9'(base + i)), got, refMem[9'(base + i)]);
         end
      end
   endtask

   task automatic waitHalted();
      logic [31:0] status;
      status = '0;
      while (!status[1]) readReg(`REG_STATUS, status);
   endtask

   task automatic runProgram(input int base);
      writeReg(`REG_PCINIT, base);
      writeReg(`REG_CTRL, 32'd1);
      waitHalted();
   endtask

   initial begin
      logic [31:0] got;
      logic [1:0]  resp;
      int          immA;
      int          immB;
      int          immC;
      int          loopN;
      lfsr = 32'h4641_e6b3;
      dataErrs = 0;
      respErrs = 0;
      rstN = 1'b0;
      awAddr = '0;
      awValid = 1'b0;
      wData = '0;
      wValid = 1'b0;
      bReady = 1'b0;
      arAddr = '0;
      arValid = 1'b0;
      rReady = 1'b0;
      for (int i = 0; i < `REG_COUNT; i++) begin
         refRegs[i] = '0;
      end
      repeat (10) @(negedge Clock);
      rstN = 1'b1;
      @(negedge Clock);

      // Memory window loopback with auto-increment
      for (int i = 0; i < 48; i++) begin
         refMem[9'(Base1 + i)] = randBits(32);
      end
      loadWindow(Base1, 48);
      readReg(`REG_MEMADDR, got);
      if (got !== 32'(Base1 + 48)) flagValue("MEMADDR after load", got, 32'(Base1 + 48));
      checkWindow(Base1, 48);
      readReg(`REG_MEMADDR, got);
      if (got !== 32'(Base1 + 48)) flagValue("MEMADDR after readback", got, 32'(Base1 + 48));

      // Register ALU ops on random operands
      fillWindow(Base2);
      emitPtr = 9'(Base2);
      immA = int'(randBits(19));
      immB = int'(randBits(19));
      immC = int'(randBits(19));
      emit(encI(cpuPkg::opAddi, 1, 0, immA));
      emit(encI(cpuPkg::opAddi, 2, 0, immB));
      emit(encR(cpuPkg::opAdd, 3, 1, 2));
      emit(encR(cpuPkg::opSub, 4, 1, 2));
      emit(encR(cpuPkg::opAnd, 5, 1, 2));
      emit(encR(cpuPkg::opOr, 6, 1, 2));
      emit(encR(cpuPkg::opShl, 7, 1, 2));
      emit(encI(cpuPkg::opAddi, 8, 3, immC));
      for (int r = 3; r <= 8; r++) begin
         emit(encI(cpuPkg::opSt, r, 0, Base2 + 32 + r));
      end
      emit(encR(cpuPkg::opHalt, 0, 0, 0));
      loadWindow(Base2, Window);
      runProgram(Base2);
      refRun(Base2);
      checkWindow(Base2, Window);

      // Loads with base 0 and signed offsets
      fillWindow(Base3);
      for (int i = 0; i < 4; i++) begin
         refMem[9'(Base3 + 32 + i)] = randBits(32);
      end
      emitPtr = 9'(Base3);
      emit(encI(cpuPkg::opAddi, 0, 0, 77));
      emit(encI(cpuPkg::opLd, 1, 0, Base3 + 32));
      emit(encI(cpuPkg::opAddi, 10, 11, Base3 + 40));
      emit(encI(cpuPkg::opLd, 2, 10, -7));
      emit(encI(cpuPkg::opLd, 3, 10, -6));
      emit(encR(cpuPkg::opAdd, 4, 1, 2));
      emit(encR(cpuPkg::opSub, 5, 3, 1));
      emit(encR(cpuPkg::opShl, 6, 2, 3));
      emit(encI(cpuPkg::opSt, 4, 0, Base3 + 48));
      emit(encI(cpuPkg::opSt, 5, 10, 9));
      emit(encI(cpuPkg::opSt, 6, 0, Base3 + 50));
      emit(encI(cpuPkg::opSt, 0, 0, Base3 + 51));
      emit(encR(cpuPkg::opHalt, 0, 0, 0));
      loadWindow(Base3, Window);
      runProgram(Base3);
      refRun(Base3);
      checkWindow(Base3, Window);

      // Countdown loop, r11 stays zero for the unconditional branch
      fillWindow(Base4);
      loopN = 12 + int'(randBits(3));
      emitPtr = 9'(Base4);
      emit(encI(cpuPkg::opAddi, 1, 11, loopN));
      emit(encI(cpuPkg::opAddi, 2, 11, 0));
      emit(encI(cpuPkg::opBrzr, 1, 0, 3));
      emit(encI(cpuPkg::opAddi, 1, 1, -1));
      emit(encI(cpuPkg::opAddi, 2, 2, 1));
      emit(encI(cpuPkg::opBrzr, 11, 0, -4));
      emit(encI(cpuPkg::opSt, 2, 0, Base4 + 32));
      emit(encI(cpuPkg::opSt, 1, 0, Base4 + 33));
      emit(encR(cpuPkg::opHalt, 0, 0, 0));
      loadWindow(Base4, Window);
      writeReg(`REG_PCINIT, Base4);
      writeReg(`REG_MEMADDR, Base4 + 40);
      writeReg(`REG_CTRL, 32'd1);

      // Host access while the loop runs
      readReg(`REG_STATUS, got);
      if (got !== 32'd1) flagValue("STATUS while running", got, 32'd1);
      axiWrite(`REG_MEMDATA, 32'hDEAD_BEEF, resp);
      if (resp !== SlvErr) flagResp("MEMDATA write while running", resp, SlvErr);
      axiRead(`REG_MEMDATA, got, resp);
      if (resp !== SlvErr) flagResp("MEMDATA read while running", resp, SlvErr);
      readReg(`REG_MEMADDR, got);
      if (got !== 32'(Base4 + 40)) flagValue("MEMADDR while running", got, 32'(Base4 + 40));
      waitHalted();
      readReg(`REG_STATUS, got);
      if (got !== 32'd2) flagValue("STATUS after halt", got, 32'd2);
      refRun(Base4);
      if (refMem[9'(Base4 + 32)] !== 32'(loopN)) begin
         flagValue("model loop count", refMem[9'(Base4 + 32)], 32'(loopN));
      end
      checkWindow(Base4, Window);

      $display("Error counts: %0d data, %0d response", dataErrs, respErrs);
      if (dataErrs == 0 && respErrs == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule
